/* bench/updi_link_tb.sv */
// testbench for the UPDI host link: random commands, ACK responder, serial line decoder, byte model
`timescale 1ns/1ps
`default_nettype none

module updi_link_tb;

	localparam int num_cmds = 60;
	// from this command on, only STS with immediate ACKs and no gaps
	localparam int fast_from = 40;
	localparam int cpb = updi_pkg::updi_clks_per_bit;
	localparam int bit_ns = 4 * cpb;

	logic clk = 1'b0;
	logic rst;
	logic cmd_start;
	updi_pkg::updi_cmd_e cmd;
	logic [3:0] cmd_reg;
	logic [15:0] cmd_addr;
	logic [7:0] cmd_data;
	logic ack_received;
	logic ready;
	logic done;
	logic waiting_for_ack;
	logic updi_tx;

	// expected line bytes, each with the number of ACKs that must precede it
	logic [7:0] exp_bytes [$];
	int exp_acks [$];
	int acks_expected = 0;
	int ack_count = 0;
	int done_count = 0;
	int wait_rises = 0;
	logic wait_prev = 1'b0;
	logic full_seen = 1'b0;
	logic ack_fast = 1'b0;
	logic [31:0] cmd_rng = 32'd37;
	logic [31:0] ack_rng = 32'd37;
	int ack_delay;
	time last_start;
	logic have_last = 1'b0;
	int checks = 0;
	int errors = 0;

	always #2 clk = ~clk;

	updi_link UUT (
		.clk(clk),
		.rst(rst),
		.cmd_start(cmd_start),
		.cmd(cmd),
		.cmd_reg(cmd_reg),
		.cmd_addr(cmd_addr),
		.cmd_data(cmd_data),
		.ready(ready),
		.done(done),
		.waiting_for_ack(waiting_for_ack),
		.ack_received(ack_received),
		.updi_tx(updi_tx)
	);

	function automatic logic [15:0] lcg_next(inout logic [31:0] state);
		state = state * 32'd1664525 + 32'd1013904223;
		return state[31:16];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("[ERROR] %0t ns %s: expected %0h, got %0h", $time, name, want, got);
		end
	endtask

	task automatic expect_byte(input logic [7:0] value, input int acks);
		exp_bytes.push_back(value);
		exp_acks.push_back(acks);
	endtask

	task automatic check_reset_outputs();
		check_value("updi_tx", updi_tx, 1);
		check_value("done", done, 0);
		check_value("waiting_for_ack", waiting_for_ack, 0);
		check_value("ready", ready, 0);
	endtask

	task automatic wait_ready(input int limit, output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < limit && !ok; n++) begin
			@(posedge clk);
			ok = (ready === 1'b1);
		end
		checks++;
		assert (ok) else begin
			errors++;
			$display("timeout at %0t ns: ready stayed low for %0d cycles", $time, limit);
		end
	endtask

	task automatic run_command(input bit fast, output bit ok);
		logic [1:0] kind;
		logic [3:0] reg_idx;
		logic [15:0] addr;
		logic [7:0] value;
		int done_before;
		int rises_before;
		int n;
		if (!fast) begin
			repeat (lcg_next(cmd_rng) % 4) @(posedge clk);
		end
		wait_ready(8, ok);
		if (!ok) begin
			return;
		end
		kind = fast ? 2'd2 : 2'(lcg_next(cmd_rng) % 3);
		reg_idx = lcg_next(cmd_rng) % 16;
		addr = lcg_next(cmd_rng);
		value = lcg_next(cmd_rng) % 256;

		// SYNCH, opcode, then data bytes; STS waits for ACK after address high and data
		expect_byte(8'h55, acks_expected);
		case (kind)
			2'd0: expect_byte(8'h80 | reg_idx, acks_expected);
			2'd1: begin
				expect_byte(8'hC0 | reg_idx, acks_expected);
				expect_byte(value, acks_expected);
			end
			default: begin
				expect_byte(8'h44, acks_expected);
				expect_byte(addr[7:0], acks_expected);
				expect_byte(addr[15:8], acks_expected);
				expect_byte(value, acks_expected + 1);
				acks_expected += 2;
			end
		endcase

		cmd_start <= 1'b1;
		cmd <= updi_pkg::updi_cmd_e'(kind);
		cmd_reg <= reg_idx;
		cmd_addr <= addr;
		cmd_data <= value;
		@(posedge clk);
		cmd_start <= 1'b0;
		done_before = done_count;
		rises_before = wait_rises;
		@(posedge clk);
		check_value("ready", ready, 0);

		ok = 1'b0;
		for (n = 0; n < 4000 && !ok; n++) begin
			@(posedge clk);
			ok = (done_count != done_before);
		end
		checks++;
		assert (ok) else begin
			errors++;
			$display("timeout at %0t ns: no done pulse for a command of kind %0d", $time, kind);
		end
		if (!ok) begin
			return;
		end
		check_value("waiting_for_ack rises", wait_rises - rises_before, (kind == 2'd2) ? 2 : 0);
		wait_ready(4, ok);
		check_value("done pulses", done_count - done_before, 1);
	endtask

	task automatic decode_frame();
		logic [7:0] rx;
		logic [7:0] want;
		logic start_bit;
		logic par;
		logic stop1;
		logic stop2;
		int acks_now;
		int need;
		acks_now = ack_count;
		checks++;
		assert (!have_last || ($time - last_start >= 12 * bit_ns)) else begin
			errors++;
			$display("frame at %0t ns started before the previous frame's 12 bit times ended",
				$time);
		end
		last_start = $time;
		have_last = 1'b1;

		// sample near the middle of each bit, on the falling clock edge
		repeat (cpb / 2) @(negedge clk);
		start_bit = updi_tx;
		for (int i = 0; i < 8; i++) begin
			repeat (cpb) @(negedge clk);
			rx[i] = updi_tx;
		end
		repeat (cpb) @(negedge clk);
		par = updi_tx;
		repeat (cpb) @(negedge clk);
		stop1 = updi_tx;
		repeat (cpb) @(negedge clk);
		stop2 = updi_tx;

		checks++;
		assert (start_bit === 1'b0 && par === ^rx && stop1 === 1'b1 && stop2 === 1'b1) else begin
			errors++;
			$display("bad frame at %0t ns: start bit, even parity or stop bits are wrong", $time);
		end
		checks++;
		assert (exp_bytes.size() != 0) else begin
			errors++;
			$display("unexpected byte %h on updi_tx at %0t ns", rx, $time);
		end
		if (exp_bytes.size() != 0) begin
			want = exp_bytes.pop_front();
			need = exp_acks.pop_front();
			check_value("updi_tx byte", rx, want);
			checks++;
			assert (acks_now >= need) else begin
				errors++;
				$display("byte %h left on updi_tx at %0t ns before its ACK was given", rx, $time);
			end
		end
	endtask

	task automatic finish_run();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end
		else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	// ACK responder
	always begin
		@(posedge clk);
		if (!rst && waiting_for_ack) begin
			ack_delay = ack_fast ? 0 : lcg_next(ack_rng) % 21;
			repeat (ack_delay) @(posedge clk);
			ack_received <= 1'b1;
			ack_count++;
			@(posedge clk);
			ack_received <= 1'b0;
		end
	end

	// pulse counters, sampled between rising edges
	always @(negedge clk) begin
		if (!rst) begin
			if (done) begin
				done_count++;
				// a command only completes once all of its ACKs have been given
				checks++;
				assert (ack_count >= acks_expected) else begin
					errors++;
					$display("done pulsed at %0t ns before the command's ACKs were given",
						$time);
				end
			end
			if (waiting_for_ack && !wait_prev) begin
				wait_rises++;
			end
			if (UUT.fifo_full) begin
				full_seen = 1'b1;
			end
		end
		wait_prev = waiting_for_ack;
	end

	// serial line decoder
	always begin
		@(negedge updi_tx);
		if (!rst) begin
			decode_frame();
		end
	end

	initial begin
		for (int n = 0; n < 400000; n++) begin
			@(posedge clk);
		end
		errors++;
		$display("simulation watchdog expired at %0t ns", $time);
		finish_run();
	end

	initial begin
		bit ok;
		int n;
		rst = 1'b1;
		cmd_start = 1'b0;
		cmd = updi_pkg::updi_cmd_ldcs;
		cmd_reg = '0;
		cmd_addr = '0;
		cmd_data = '0;
		ack_received = 1'b0;
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			if (i > 0) begin
				check_reset_outputs();
			end
		end
		rst <= 1'b0;
		wait_ready(4, ok);
		check_value("updi_tx", updi_tx, 1);
		check_value("done", done, 0);
		check_value("waiting_for_ack", waiting_for_ack, 0);

		for (n = 0; n < num_cmds && ok; n++) begin
			if (n == fast_from) begin
				ack_fast = 1'b1;
			end
			run_command(n >= fast_from, ok);
		end

		if (ok) begin
			// let the transmitter drain the FIFO
			for (n = 0; n < 4000 && exp_bytes.size() != 0; n++) begin
				@(posedge clk);
			end
			checks++;
			assert (exp_bytes.size() == 0) else begin
				errors++;
				$display("timeout: %0d expected bytes never appeared on updi_tx", exp_bytes.size());
			end
			check_value("done pulses total", done_count, num_cmds);
			checks++;
			assert (full_seen) else begin
				errors++;
				$display("the FIFO never reached full during the back-to-back STS commands");
			end
		end
		finish_run();
	end

endmodule

`default_nettype wire

/* logic/updi_byte_fifo.sv */
// synchronous byte FIFO between the sequencer and the serial transmitter, early full flag
`timescale 1ns/1ps
`default_nettype none

module updi_byte_fifo (
	input wire clk,
	input wire rst,

	input wire wr_en,
	input wire updi_pkg::updi_byte_t wr_data,
	input wire rd_en,

	output updi_pkg::updi_byte_t rd_data,
	output logic full,
	output logic empty
);

	updi_pkg::updi_byte_t mem [updi_pkg::updi_fifo_depth];
	logic [$clog2(updi_pkg::updi_fifo_depth)-1:0] wr_ptr;
	logic [$clog2(updi_pkg::updi_fifo_depth)-1:0] rd_ptr;
	logic [$clog2(updi_pkg::updi_fifo_depth):0] count;

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// show-ahead read of the head entry
	assign rd_data = mem[rd_ptr];
	assign empty = (count == 0);
	// one entry early, leaves room for the write already in flight
	assign full = (count >= updi_pkg::updi_fifo_depth - 1);

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		(count == updi_pkg::updi_fifo_depth) |-> !wr_en);

	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		rd_en |-> !empty);

endmodule

`default_nettype wire

/* logic/updi_instruction_converter.sv */
// host command latch producing the UPDI opcode, data bytes, length and ACK mask
`timescale 1ns/1ps
`default_nettype none

module updi_instruction_converter (
	input wire clk,
	input wire rst,

	// host side
	input wire cmd_start,
	input wire updi_pkg::updi_cmd_e cmd,
	input wire updi_pkg::updi_cs_reg_t cmd_reg,
	input wire updi_pkg::updi_addr_t cmd_addr,
	input wire updi_pkg::updi_byte_t cmd_data,
	output logic ready,

	// sequencer side
	input wire hdlr_ready,
	input wire hdlr_done,
	output logic start,
	output updi_pkg::updi_byte_t opcode,
	output updi_pkg::updi_byte_t data [updi_pkg::updi_max_data],
	output updi_pkg::updi_len_t data_len,
	output updi_pkg::updi_ack_mask_t wait_ack_after
);

	logic busy;
	logic accept;

	// busy covers the cycle before the handler drops its own ready
	assign ready = hdlr_ready && !busy;
	assign accept = cmd_start && ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			start <= 1'b0;
		end
		else begin
			start <= accept;
			if (accept) begin
				busy <= 1'b1;
			end
			else if (hdlr_done) begin
				busy <= 1'b0;
			end
		end
	end

	// command payload, stable until the handler reports done
	always_ff @(posedge clk) begin
		if (accept) begin
			for (int i = 0; i < updi_pkg::updi_max_data; i++) begin
				data[i] <= '0;
			end
			data_len <= '0;
			wait_ack_after <= '0;

			case (cmd)
				updi_pkg::updi_cmd_stcs: begin
					opcode <= updi_pkg::updi_op_stcs_base | {4'h0, cmd_reg};
					data[0] <= cmd_data;
					data_len <= updi_pkg::updi_len_t'(1);
				end

				updi_pkg::updi_cmd_sts: begin
					opcode <= updi_pkg::updi_op_sts_b16;
					data[0] <= cmd_addr[7:0];
					data[1] <= cmd_addr[15:8];
					data[2] <= cmd_data;
					data_len <= updi_pkg::updi_len_t'(3);
					// target ACKs the address and then the data byte
					wait_ack_after <= updi_pkg::updi_ack_mask_t'(4'b0110);
				end

				default: begin
					// LDCS, opcode only
					opcode <= updi_pkg::updi_op_ldcs_base | {4'h0, cmd_reg};
				end
			endcase
		end
	end

	// host must respect ready, which depends on the sequencer as well
	a_start_when_ready: assert property (@(posedge clk) disable iff (rst)
		cmd_start |-> ready);

endmodule

`default_nettype wire

/* logic/updi_instruction_queue_handler.sv */
// UPDI byte sequencer writing SYNCH, opcode and data bytes into the TX FIFO with ACK pauses
`timescale 1ns/1ps
`default_nettype none

module updi_instruction_queue_handler (
	input wire clk,
	input wire rst,

	// control
	input wire start,
	output logic ready,
	output logic done,
	output logic waiting_for_ack,
	input wire ack_received,

	// command from the converter
	input wire updi_pkg::updi_byte_t opcode,
	input wire updi_pkg::updi_byte_t data [updi_pkg::updi_max_data],
	input wire updi_pkg::updi_len_t data_len,
	input wire updi_pkg::updi_ack_mask_t wait_ack_after,

	// FIFO write side
	output updi_pkg::updi_byte_t fifo_data,
	output logic fifo_wr_en,
	input wire fifo_full
);

	updi_pkg::updi_hdlr_state_e state;
	updi_pkg::updi_len_t counter;
	logic [$clog2(updi_pkg::updi_max_data)-1:0] idx;
	logic last_byte;

	assign idx = counter[$clog2(updi_pkg::updi_max_data)-1:0];
	assign last_byte = (updi_pkg::updi_len_t'(counter + 1'b1) == data_len);

	always_ff @(posedge clk) begin
		// strobes default low
		fifo_wr_en <= 1'b0;
		waiting_for_ack <= 1'b0;
		done <= 1'b0;

		if (rst) begin
			state <= updi_pkg::hdlr_idle;
			ready <= 1'b0;
			counter <= '0;
		end
		else begin
			case (state)
				updi_pkg::hdlr_idle: begin
					if (start) begin
						ready <= 1'b0;
						state <= updi_pkg::hdlr_wr_synch;
					end
					else begin
						ready <= 1'b1;
					end
				end

				updi_pkg::hdlr_wr_synch: begin
					if (!fifo_full) begin
						fifo_data <= updi_pkg::updi_synch;
						fifo_wr_en <= 1'b1;
						state <= updi_pkg::hdlr_wr_opcode;
					end
				end

				updi_pkg::hdlr_wr_opcode: begin
					if (!fifo_full) begin
						fifo_data <= opcode;
						fifo_wr_en <= 1'b1;
						counter <= '0;
						// LDCS has no data bytes
						if (data_len != '0) begin
							state <= updi_pkg::hdlr_wr_data;
						end
						else begin
							state <= updi_pkg::hdlr_idle;
							done <= 1'b1;
						end
					end
				end

				updi_pkg::hdlr_wr_data: begin
					if (!fifo_full) begin
						fifo_data <= data[idx];
						fifo_wr_en <= 1'b1;
						// an ACK already here skips the wait state
						if (wait_ack_after[idx] && !ack_received) begin
							state <= updi_pkg::hdlr_wait_ack;
						end
						else if (last_byte) begin
							state <= updi_pkg::hdlr_idle;
							done <= 1'b1;
						end
						else begin
							counter <= counter + 1'b1;
						end
					end
				end

				updi_pkg::hdlr_wait_ack: begin
					if (ack_received) begin
						if (last_byte) begin
							state <= updi_pkg::hdlr_idle;
							done <= 1'b1;
						end
						else begin
							counter <= counter + 1'b1;
							state <= updi_pkg::hdlr_wr_data;
						end
					end
					else begin
						waiting_for_ack <= 1'b1;
					end
				end

				default: begin
					state <= updi_pkg::hdlr_idle;
				end
			endcase
		end
	end

	// the write lands a cycle after the decision, so full must block the next write
	a_no_write_after_full: assert property (@(posedge clk) disable iff (rst)
		fifo_full |=> !fifo_wr_en);

endmodule

`default_nettype wire

/* logic/updi_link.sv */
// top level of the UPDI host link: converter, sequencer, byte FIFO and serial transmitter
`timescale 1ns/1ps
`default_nettype none

module updi_link (
	input wire clk,
	input wire rst,

	input wire cmd_start,
	input wire updi_pkg::updi_cmd_e cmd,
	input wire updi_pkg::updi_cs_reg_t cmd_reg,
	input wire updi_pkg::updi_addr_t cmd_addr,
	input wire updi_pkg::updi_byte_t cmd_data,
	output logic ready,
	output logic done,
	output logic waiting_for_ack,
	input wire ack_received,

	output logic updi_tx
);

	// converter to sequencer
	logic hdlr_ready;
	logic hdlr_start;
	updi_pkg::updi_byte_t seq_opcode;
	updi_pkg::updi_byte_t seq_data [updi_pkg::updi_max_data];
	updi_pkg::updi_len_t seq_len;
	updi_pkg::updi_ack_mask_t seq_ack_mask;

	// sequencer to FIFO to transmitter
	updi_pkg::updi_byte_t fifo_wr_data;
	logic fifo_wr_en;
	logic fifo_full;
	updi_pkg::updi_byte_t fifo_rd_data;
	logic fifo_rd_en;
	logic fifo_empty;

	updi_instruction_converter u_converter (
		.clk(clk), .rst(rst),
		.cmd_start(cmd_start), .cmd(cmd), .cmd_reg(cmd_reg),
		.cmd_addr(cmd_addr), .cmd_data(cmd_data), .ready(ready),
		.hdlr_ready(hdlr_ready), .hdlr_done(done), .start(hdlr_start),
		.opcode(seq_opcode), .data(seq_data), .data_len(seq_len),
		.wait_ack_after(seq_ack_mask)
	);

	updi_instruction_queue_handler u_handler (
		.clk(clk), .rst(rst),
		.start(hdlr_start), .ready(hdlr_ready), .done(done),
		.waiting_for_ack(waiting_for_ack), .ack_received(ack_received),
		.opcode(seq_opcode), .data(seq_data), .data_len(seq_len),
		.wait_ack_after(seq_ack_mask),
		.fifo_data(fifo_wr_data), .fifo_wr_en(fifo_wr_en), .fifo_full(fifo_full)
	);

	updi_byte_fifo u_fifo (
		.clk(clk), .rst(rst),
		.wr_en(fifo_wr_en), .wr_data(fifo_wr_data), .rd_en(fifo_rd_en),
		.rd_data(fifo_rd_data), .full(fifo_full), .empty(fifo_empty)
	);

	updi_serial_tx u_tx (
		.clk(clk), .rst(rst),
		.empty(fifo_empty), .rd_data(fifo_rd_data), .rd_en(fifo_rd_en),
		.updi_tx(updi_tx)
	);

endmodule

`default_nettype wire

/* logic/updi_pkg.sv */
// widths, commands, state encodings, protocol constants and timing of the UPDI host link
`default_nettype none

package updi_pkg;

	// sizes
	localparam int updi_max_data = 4;
	localparam int updi_fifo_depth = 8;
	localparam int updi_clks_per_bit = 8;

	typedef logic [7:0] updi_byte_t;
	typedef logic [15:0] updi_addr_t;
	typedef logic [3:0] updi_cs_reg_t;

	// one extra bit so a full buffer length fits
	typedef logic [$clog2(updi_max_data):0] updi_len_t;

	// bit i set means wait for ACK after data byte i
	typedef logic [updi_max_data-1:0] updi_ack_mask_t;

	// protocol characters and opcodes
	localparam updi_byte_t updi_synch = 8'h55;
	localparam updi_byte_t updi_op_ldcs_base = 8'h80;
	localparam updi_byte_t updi_op_stcs_base = 8'hC0;
	localparam updi_byte_t updi_op_sts_b16 = 8'h44;

	typedef enum logic [1:0] {
		updi_cmd_ldcs,
		updi_cmd_stcs,
		updi_cmd_sts
	} updi_cmd_e;

	// byte sequencer
	typedef enum logic [2:0] {
		hdlr_idle,
		hdlr_wr_synch,
		hdlr_wr_opcode,
		hdlr_wr_data,
		hdlr_wait_ack
	} updi_hdlr_state_e;

	// serial frame transmitter
	typedef enum logic [2:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_parity,
		tx_stop
	} updi_tx_state_e;

endpackage

`default_nettype wire

/* logic/updi_serial_tx.sv */
// UPDI frame transmitter: start bit, 8 data bits LSB first, even parity, two stop bits
`timescale 1ns/1ps
`default_nettype none

module updi_serial_tx (
	input wire clk,
	input wire rst,

	input wire empty,
	input wire updi_pkg::updi_byte_t rd_data,
	output logic rd_en,

	output logic updi_tx
);

	updi_pkg::updi_tx_state_e state;
	logic [$clog2(updi_pkg::updi_clks_per_bit)-1:0] clk_cnt;
	logic [2:0] bit_cnt;
	updi_pkg::updi_byte_t shift_reg;
	logic parity_bit;
	logic bit_end;
	logic pop;

	assign bit_end = (clk_cnt == updi_pkg::updi_clks_per_bit - 1);

	// pop when idle, or in the last cycle of the second stop bit for back to back frames
	assign pop = !empty && ((state == updi_pkg::tx_idle) ||
		(state == updi_pkg::tx_stop && bit_end && bit_cnt == 3'd1));
	assign rd_en = pop;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= updi_pkg::tx_idle;
			updi_tx <= 1'b1;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (pop) begin
			shift_reg <= rd_data;
			parity_bit <= ^rd_data;
			state <= updi_pkg::tx_start;
			updi_tx <= 1'b0;
			clk_cnt <= '0;
		end
		else if (state != updi_pkg::tx_idle) begin
			clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
			if (bit_end) begin
				case (state)
					updi_pkg::tx_start: begin
						state <= updi_pkg::tx_data;
						updi_tx <= shift_reg[0];
						bit_cnt <= '0;
					end
					updi_pkg::tx_data: begin
						if (bit_cnt == 3'd7) begin
							state <= updi_pkg::tx_parity;
							updi_tx <= parity_bit;
						end
						else begin
							shift_reg <= shift_reg >> 1;
							updi_tx <= shift_reg[1];
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
					updi_pkg::tx_parity: begin
						state <= updi_pkg::tx_stop;
						updi_tx <= 1'b1;
						bit_cnt <= '0;
					end
					default: begin
						// stop bits, line stays high; FIFO was empty at the end
						if (bit_cnt == 3'd1) begin
							state <= updi_pkg::tx_idle;
						end
						else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* vlog.f */
logic/updi_pkg.sv
logic/updi_instruction_converter.sv
logic/updi_instruction_queue_handler.sv
logic/updi_byte_fifo.sv
logic/updi_serial_tx.sv
logic/updi_link.sv
bench/updi_link_tb.sv
